// ==== logic/core_cfg.svh ====
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// data and address width
`define XLEN 32
`define REG_COUNT 32
// first fetch after reset
`define RESET_PC 32'h0000_0000
// every mul, divu and remu runs this many iterations
`define MUL_DIV_STEPS 32

`endif

// ==== logic/rv_isa_pkg.sv ====
`default_nettype none

`include "core_cfg.svh"

package rv_isa_pkg;

  typedef logic [`XLEN-1:0] word_t;
  typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t;
  typedef logic [`XLEN/8-1:0] wstrb_t;

  // major opcodes of the kept subset
  typedef enum logic [6:0] {
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011
  } opcode_t;

  typedef enum logic [4:0] {
    op_add, op_sub, op_sll, op_slt, op_sltu, op_xor, op_srl, op_sra, op_or, op_and,
    op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
    op_lui, op_auipc, op_jal, op_jalr, op_lw, op_sw,
    op_mul, op_divu, op_remu
  } exec_op_t;

endpackage

`default_nettype wire

// ==== logic/core_ctrl_pkg.sv ====
`default_nettype none

`include "core_cfg.svh"

package core_ctrl_pkg;

  typedef enum logic [3:0] {
    st_fetch, st_wait_fetch, st_execute, st_mul_div, st_wait_load,
    st_wait_store, st_check_pc, st_write_back, st_halted
  } core_state_t;

  // wide enough to hold the full step count itself
  typedef logic [$clog2(`MUL_DIV_STEPS):0] step_count_t;

endpackage

`default_nettype wire

// ==== logic/instr_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module instr_decoder (
  input  rv_isa_pkg::word_t    instr,
  output rv_isa_pkg::reg_idx_t rs1,
  output rv_isa_pkg::reg_idx_t rs2,
  output rv_isa_pkg::reg_idx_t rd,
  output rv_isa_pkg::word_t    imm,
  output rv_isa_pkg::exec_op_t op,
  output logic                 legal
);
  import rv_isa_pkg::*;

  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t imm_i;
  word_t imm_s;
  word_t imm_b;
  word_t imm_u;
  word_t imm_j;

  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rs1 = instr[19:15];
  assign rd = instr[11:7];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    op = op_add;
    legal = 1'b1;
    imm = imm_i;
    rs2 = instr[24:20];
    case (opcode_t'(instr[6:0]))
      opc_lui: begin
        op = op_lui;
        imm = imm_u;
      end
      opc_auipc: begin
        op = op_auipc;
        imm = imm_u;
      end
      opc_jal: begin
        op = op_jal;
        imm = imm_j;
      end
      opc_jalr: begin
        op = op_jalr;
        legal = (funct3 == 3'b000);
      end
      opc_branch: begin
        imm = imm_b;
        case (funct3)
          3'b000: op = op_beq;
          3'b001: op = op_bne;
          3'b100: op = op_blt;
          3'b101: op = op_bge;
          3'b110: op = op_bltu;
          3'b111: op = op_bgeu;
          default: legal = 1'b0;
        endcase
      end
      opc_load: begin
        op = op_lw;
        legal = (funct3 == 3'b010);
      end
      opc_store: begin
        op = op_sw;
        imm = imm_s;
        legal = (funct3 == 3'b010);
      end
      opc_op_imm: begin
        // second source reads x0 so the ALU sees only the immediate
        rs2 = '0;
        case (funct3)
          3'b000: op = op_add;
          3'b010: op = op_slt;
          3'b011: op = op_sltu;
          3'b100: op = op_xor;
          3'b110: op = op_or;
          3'b111: op = op_and;
          3'b001: begin
            op = op_sll;
            legal = (funct7 == 7'b0000000);
          end
          default: begin
            op = funct7[5] ? op_sra : op_srl;
            legal = ({funct7[6], funct7[4:0]} == 6'b000000);
          end
        endcase
      end
      opc_op: begin
        imm = '0;
        case ({funct7, funct3})
          10'b0000000_000: op = op_add;
          10'b0100000_000: op = op_sub;
          10'b0000000_001: op = op_sll;
          10'b0000000_010: op = op_slt;
          10'b0000000_011: op = op_sltu;
          10'b0000000_100: op = op_xor;
          10'b0000000_101: op = op_srl;
          10'b0100000_101: op = op_sra;
          10'b0000000_110: op = op_or;
          10'b0000000_111: op = op_and;
          10'b0000001_000: op = op_mul;
          10'b0000001_101: op = op_divu;
          10'b0000001_111: op = op_remu;
          default: legal = 1'b0;
        endcase
      end
      default: legal = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "core_cfg.svh"

module reg_file (
  input  logic                          clk,
  input  logic [$clog2(`REG_COUNT)-1:0] rs1,
  input  logic [$clog2(`REG_COUNT)-1:0] rs2,
  output logic [`XLEN-1:0]              rs1_data,
  output logic [`XLEN-1:0]              rs2_data,
  input  logic                          we,
  input  logic [$clog2(`REG_COUNT)-1:0] rd,
  input  logic [`XLEN-1:0]              rd_data
);

  logic [`XLEN-1:0] regs [`REG_COUNT];

  // x0 is never written and always reads as zero
  always_ff @(posedge clk) begin
    if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== logic/exec_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module exec_unit (
  input  rv_isa_pkg::exec_op_t op,
  input  rv_isa_pkg::word_t    pc,
  input  rv_isa_pkg::word_t    imm,
  input  rv_isa_pkg::word_t    rs1_data,
  input  rv_isa_pkg::word_t    rs2_data,
  output rv_isa_pkg::word_t    result,
  output rv_isa_pkg::word_t    target,
  output rv_isa_pkg::word_t    ls_addr,
  output logic                 taken
);
  import rv_isa_pkg::*;

  word_t operand_b;
  word_t pc_plus4;
  logic [4:0] shamt;

  // the decoder zeroes whichever second source is not in use
  assign operand_b = rs2_data | imm;
  assign shamt = operand_b[4:0];
  assign pc_plus4 = pc + word_t'(4);

  assign ls_addr = rs1_data + imm;
  assign target = (op == op_jalr) ? {ls_addr[31:1], 1'b0} : pc + imm;

  always_comb begin
    case (op)
      op_sub:   result = rs1_data - operand_b;
      op_sll:   result = rs1_data << shamt;
      op_slt:   result = {31'b0, $signed(rs1_data) < $signed(operand_b)};
      op_sltu:  result = {31'b0, rs1_data < operand_b};
      op_xor:   result = rs1_data ^ operand_b;
      op_srl:   result = rs1_data >> shamt;
      op_sra:   result = $signed(rs1_data) >>> shamt;
      op_or:    result = rs1_data | operand_b;
      op_and:   result = rs1_data & operand_b;
      op_lui:   result = imm;
      op_auipc: result = pc + imm;
      op_jal,
      op_jalr:  result = pc_plus4;
      default:  result = rs1_data + operand_b;
    endcase
  end

  always_comb begin
    case (op)
      op_beq:  taken = (rs1_data == rs2_data);
      op_bne:  taken = (rs1_data != rs2_data);
      op_blt:  taken = $signed(rs1_data) < $signed(rs2_data);
      op_bge:  taken = $signed(rs1_data) >= $signed(rs2_data);
      op_bltu: taken = rs1_data < rs2_data;
      op_bgeu: taken = rs1_data >= rs2_data;
      op_jal,
      op_jalr: taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/mul_div_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module mul_div_unit (
  input  logic                 clk,
  input  logic                 start,
  input  logic                 step,
  input  rv_isa_pkg::exec_op_t op,
  input  rv_isa_pkg::word_t    rs1_data,
  input  rv_isa_pkg::word_t    rs2_data,
  output rv_isa_pkg::word_t    mul_div_result
);
  import rv_isa_pkg::*;

  // acc holds the partial product or the running remainder
  word_t acc;
  // x is the shifted multiplicand, or the dividend turning into the quotient
  word_t x;
  word_t y;
  logic [32:0] rem_shift;
  logic [32:0] diff;

  assign rem_shift = {acc, x[31]};
  assign diff = rem_shift - {1'b0, y};

  always_ff @(posedge clk) begin
    if (start) begin
      acc <= '0;
      x <= rs1_data;
      y <= rs2_data;
    end else if (step) begin
      if (op == op_mul) begin
        acc <= y[0] ? acc + x : acc;
        x <= x << 1;
        y <= y >> 1;
      end else if (!diff[32]) begin
        // divisor fits, so keep the difference and shift in a one
        acc <= diff[31:0];
        x <= {x[30:0], 1'b1};
      end else begin
        acc <= rem_shift[31:0];
        x <= {x[30:0], 1'b0};
      end
    end
  end

  // a zero divisor always fits, giving all ones and the dividend back
  assign mul_div_result = (op == op_divu) ? x : acc;

endmodule

`default_nettype wire

// ==== logic/step_counter.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "core_cfg.svh"

module step_counter (
  input  logic clk,
  input  logic reset,
  input  logic load,
  output logic done
);
  import core_ctrl_pkg::*;

  step_count_t count;

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
      done <= 1'b0;
    end else if (load) begin
      count <= step_count_t'(`MUL_DIV_STEPS);
      done <= 1'b0;
    end else begin
      if (count != '0) begin
        count <= count - 1'b1;
      end
      // one-cycle pulse once the count has hit zero
      done <= (count == step_count_t'(1));
    end
  end

endmodule

`default_nettype wire

// ==== logic/core_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "core_cfg.svh"

module core_fsm (
  input  logic                 clk,
  input  logic                 reset,
  output logic                 mem_valid,
  output logic                 mem_instr,
  input  logic                 mem_ready,
  output rv_isa_pkg::word_t    mem_addr,
  output rv_isa_pkg::word_t    mem_wdata,
  output rv_isa_pkg::wstrb_t   mem_wstrb,
  input  rv_isa_pkg::word_t    mem_rdata,
  output logic                 trap,
  output rv_isa_pkg::word_t    instr,
  output rv_isa_pkg::word_t    pc,
  input  rv_isa_pkg::exec_op_t op,
  input  logic                 legal,
  input  rv_isa_pkg::word_t    result,
  input  rv_isa_pkg::word_t    target,
  input  rv_isa_pkg::word_t    ls_addr,
  input  logic                 taken,
  input  rv_isa_pkg::word_t    rs2_data,
  input  rv_isa_pkg::word_t    mul_div_result,
  output logic                 md_start,
  output logic                 md_step,
  output logic                 count_load,
  input  logic                 count_done,
  output logic                 rd_we,
  output rv_isa_pkg::word_t    rd_data
);
  import rv_isa_pkg::*;
  import core_ctrl_pkg::*;

  core_state_t state;
  word_t next_pc;
  word_t pc_plus4;
  logic is_mem_op;
  logic is_mul_div;
  logic md_go;

  assign pc_plus4 = pc + word_t'(4);
  assign is_mem_op = (op == op_lw) || (op == op_sw);
  assign is_mul_div = (op == op_mul) || (op == op_divu) || (op == op_remu);

  assign md_go = (state == st_execute) && legal && is_mul_div;
  assign md_start = md_go;
  assign count_load = md_go;
  assign md_step = (state == st_mul_div) && !count_done;
  assign rd_we = (state == st_write_back);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_fetch;
      pc <= `RESET_PC;
      next_pc <= `RESET_PC;
      mem_valid <= 1'b0;
      mem_wstrb <= '0;
      trap <= 1'b0;
    end else begin
      case (state)
        st_fetch: begin
          mem_valid <= 1'b1;
          mem_instr <= 1'b1;
          mem_addr <= next_pc;
          mem_wstrb <= '0;
          state <= st_wait_fetch;
        end

        st_wait_fetch: begin
          if (mem_ready) begin
            mem_valid <= 1'b0;
            instr <= mem_rdata;
            pc <= mem_addr;
            state <= st_execute;
          end
        end

        st_execute: begin
          if (!legal || (is_mem_op && ls_addr[1:0] != 2'b00)) begin
            trap <= 1'b1;
            state <= st_halted;
          end else begin
            case (op)
              op_mul, op_divu, op_remu: state <= st_mul_div;
              op_lw: begin
                mem_valid <= 1'b1;
                mem_instr <= 1'b0;
                mem_addr <= ls_addr;
                mem_wstrb <= '0;
                state <= st_wait_load;
              end
              op_sw: begin
                mem_valid <= 1'b1;
                mem_instr <= 1'b0;
                mem_addr <= ls_addr;
                mem_wdata <= rs2_data;
                mem_wstrb <= '1;
                state <= st_wait_store;
              end
              op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu, op_jal, op_jalr: begin
                rd_data <= result;
                state <= st_check_pc;
              end
              default: begin
                rd_data <= result;
                next_pc <= pc_plus4;
                state <= st_write_back;
              end
            endcase
          end
        end

        // closing cycle once all iterations are done
        st_mul_div: begin
          if (count_done) begin
            rd_data <= mul_div_result;
            next_pc <= pc_plus4;
            state <= st_write_back;
          end
        end

        st_wait_load: begin
          if (mem_ready) begin
            mem_valid <= 1'b0;
            rd_data <= mem_rdata;
            next_pc <= pc_plus4;
            state <= st_write_back;
          end
        end

        st_wait_store: begin
          if (mem_ready) begin
            mem_valid <= 1'b0;
            next_pc <= pc_plus4;
            state <= st_fetch;
          end
        end

        // untaken branches never fault on their target
        st_check_pc: begin
          if (taken && target[1:0] != 2'b00) begin
            trap <= 1'b1;
            state <= st_halted;
          end else begin
            next_pc <= taken ? target : pc_plus4;
            state <= (op == op_jal || op == op_jalr) ? st_write_back : st_fetch;
          end
        end

        st_write_back: state <= st_fetch;

        default: state <= st_halted;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/riscv_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module riscv_core (
  input  logic               clk,
  input  logic               reset,
  output logic               mem_valid,
  output logic               mem_instr,
  input  logic               mem_ready,
  output rv_isa_pkg::word_t  mem_addr,
  output rv_isa_pkg::word_t  mem_wdata,
  output rv_isa_pkg::wstrb_t mem_wstrb,
  input  rv_isa_pkg::word_t  mem_rdata,
  output logic               trap
);
  import rv_isa_pkg::*;

  word_t instr;
  word_t pc;
  reg_idx_t rs1;
  reg_idx_t rs2;
  reg_idx_t rd;
  word_t imm;
  exec_op_t op;
  logic legal;
  word_t rs1_data;
  word_t rs2_data;
  word_t result;
  word_t target;
  word_t ls_addr;
  logic taken;
  word_t mul_div_result;
  logic md_start;
  logic md_step;
  logic count_load;
  logic count_done;
  logic rd_we;
  word_t rd_data;

  core_fsm core_fsm_i (
    .clk(clk),
    .reset(reset),
    .mem_valid(mem_valid),
    .mem_instr(mem_instr),
    .mem_ready(mem_ready),
    .mem_addr(mem_addr),
    .mem_wdata(mem_wdata),
    .mem_wstrb(mem_wstrb),
    .mem_rdata(mem_rdata),
    .trap(trap),
    .instr(instr),
    .pc(pc),
    .op(op),
    .legal(legal),
    .result(result),
    .target(target),
    .ls_addr(ls_addr),
    .taken(taken),
    .rs2_data(rs2_data),
    .mul_div_result(mul_div_result),
    .md_start(md_start),
    .md_step(md_step),
    .count_load(count_load),
    .count_done(count_done),
    .rd_we(rd_we),
    .rd_data(rd_data)
  );

  step_counter step_counter_i (
    .clk(clk),
    .reset(reset),
    .load(count_load),
    .done(count_done)
  );

  instr_decoder instr_decoder_i (
    .instr(instr),
    .rs1(rs1),
    .rs2(rs2),
    .rd(rd),
    .imm(imm),
    .op(op),
    .legal(legal)
  );

  reg_file reg_file_i (
    .clk(clk),
    .rs1(rs1),
    .rs2(rs2),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .we(rd_we),
    .rd(rd),
    .rd_data(rd_data)
  );

  exec_unit exec_unit_i (
    .op(op),
    .pc(pc),
    .imm(imm),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .result(result),
    .target(target),
    .ls_addr(ls_addr),
    .taken(taken)
  );

  mul_div_unit mul_div_unit_i (
    .clk(clk),
    .start(md_start),
    .step(md_step),
    .op(op),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .mul_div_result(mul_div_result)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// instruction encoders
function automatic word_t enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                logic [2:0] f3, logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, opc_op};
endfunction

function automatic word_t enc_i(word_t imm, logic [4:0] rs1, logic [2:0] f3,
                                logic [4:0] rd, logic [6:0] opc);
  return {imm[11:0], rs1, f3, rd, opc};
endfunction

function automatic word_t enc_s(word_t imm, logic [4:0] rs2, logic [4:0] rs1);
  return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opc_store};
endfunction

function automatic word_t enc_b(word_t imm, logic [4:0] rs2, logic [4:0] rs1, logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
endfunction

function automatic word_t enc_u(word_t v, logic [4:0] rd, logic [6:0] opc);
  return {v[31:12], rd, opc};
endfunction

function automatic word_t enc_j(word_t imm, logic [4:0] rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
endfunction

function automatic void emit(word_t w);
  prog[prog_len] = w;
  prog_len++;
endfunction

// lui plus addi, with the carry of a negative low part folded into the upper half
function automatic void load_const(logic [4:0] rd, word_t v);
  emit(enc_u(v + 32'h800, rd, opc_lui));
  emit(enc_i(v, rd, 3'b000, rd, opc_op_imm));
endfunction

// x31 points at the result area
function automatic void begin_program();
  prog_len = 0;
  slot = 0;
  emit(enc_i(32'h400, 5'd0, 3'b000, 5'd31, opc_op_imm));
endfunction

function automatic void store_result(logic [4:0] rs);
  emit(enc_s(word_t'(slot), rs, 5'd31));
  slot += 4;
endfunction

function automatic word_t alu(logic [2:0] f3, logic alt, word_t a, word_t b);
  case (f3)
    3'd0: return alt ? a - b : a + b;
    3'd1: return a << b[4:0];
    3'd2: return {31'b0, $signed(a) < $signed(b)};
    3'd3: return {31'b0, a < b};
    3'd4: return a ^ b;
    3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'd6: return a | b;
    default: return a & b;
  endcase
endfunction

// runs ref_mem from the reset pc, fills the expected store list, returns instructions run
function automatic int unsigned run_reference();
  word_t x [32];
  word_t pc;
  word_t w;
  word_t a;
  word_t b;
  word_t res;
  word_t npc;
  word_t addr;
  logic [2:0] f3;
  logic [6:0] f7;
  logic we;
  logic bad;
  logic tk;
  int unsigned n;
  x = '{default: '0};
  pc = `RESET_PC;
  n = 0;
  exp_trap = 1'b0;
  exp_addr.delete();
  exp_data.delete();
  while (!exp_trap && n < 4000) begin
    w = ref_mem[pc[11:2]];
    n++;
    f3 = w[14:12];
    f7 = w[31:25];
    a = x[w[19:15]];
    b = x[w[24:20]];
    res = '0;
    we = 1'b0;
    bad = 1'b0;
    npc = pc + 4;
    case (opcode_t'(w[6:0]))
      opc_lui: begin
        res = {w[31:12], 12'b0};
        we = 1'b1;
      end
      opc_auipc: begin
        res = pc + {w[31:12], 12'b0};
        we = 1'b1;
      end
      opc_jal: begin
        res = pc + 4;
        we = 1'b1;
        npc = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      end
      opc_jalr: begin
        bad = (f3 != 3'd0);
        res = pc + 4;
        we = 1'b1;
        npc = (a + {{20{w[31]}}, w[31:20]}) & ~word_t'(1);
      end
      opc_branch: begin
        case (f3)
          3'd0: tk = (a == b);
          3'd1: tk = (a != b);
          3'd4: tk = $signed(a) < $signed(b);
          3'd5: tk = $signed(a) >= $signed(b);
          3'd6: tk = a < b;
          3'd7: tk = a >= b;
          default: begin
            tk = 1'b0;
            bad = 1'b1;
          end
        endcase
        if (tk) begin
          npc = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        end
      end
      opc_load: begin
        addr = a + {{20{w[31]}}, w[31:20]};
        bad = (f3 != 3'b010) || (addr[1:0] != 2'b00);
        res = ref_mem[addr[11:2]];
        we = 1'b1;
      end
      opc_store: begin
        addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
        bad = (f3 != 3'b010) || (addr[1:0] != 2'b00);
        if (!bad) begin
          ref_mem[addr[11:2]] = b;
          exp_addr.push_back(addr);
          exp_data.push_back(b);
        end
      end
      opc_op_imm: begin
        bad = (f3 == 3'd1 && f7 != 7'h00) || (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
        res = alu(f3, f3 == 3'd5 && f7[5], a, {{20{w[31]}}, w[31:20]});
        we = 1'b1;
      end
      opc_op: begin
        we = 1'b1;
        if (f7 == 7'h01) begin
          case (f3)
            3'd0: res = a * b;
            3'd5: res = (b == 0) ? '1 : a / b;
            3'd7: res = (b == 0) ? a : a % b;
            default: bad = 1'b1;
          endcase
        end else if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
          res = alu(f3, f7[5], a, b);
        end else begin
          bad = 1'b1;
        end
      end
      default: bad = 1'b1;
    endcase
    if (bad || npc[1:0] != 2'b00) begin
      exp_trap = 1'b1;
    end else begin
      if (we && w[11:7] != 5'd0) begin
        x[w[11:7]] = res;
      end
      pc = npc;
    end
  end
  return n;
endfunction

`endif

// ==== testbench/tb_riscv_core.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "core_cfg.svh"

module tb_riscv_core;
  import rv_isa_pkg::*;

  logic clk;
  logic reset;
  logic mem_valid;
  logic mem_instr;
  logic mem_ready;
  word_t mem_addr;
  word_t mem_wdata;
  wstrb_t mem_wstrb;
  word_t mem_rdata;
  logic trap;

  word_t mem [1024];
  word_t ref_mem [1024];
  word_t prog [256];
  int unsigned prog_len;
  int unsigned slot;
  word_t exp_addr [$];
  word_t exp_data [$];
  logic exp_trap;
  int unsigned store_idx;
  int unsigned errors;
  int unsigned tests_run;
  int unsigned tests_failed;
  int unsigned cycle_count;
  int unsigned budget;

  `include "tb_ref_model.svh"

  riscv_core riscv_core_i (
    .clk(clk),
    .reset(reset),
    .mem_valid(mem_valid),
    .mem_instr(mem_instr),
    .mem_ready(mem_ready),
    .mem_addr(mem_addr),
    .mem_wdata(mem_wdata),
    .mem_wstrb(mem_wstrb),
    .mem_rdata(mem_rdata),
    .trap(trap)
  );

  always #20 clk = ~clk;

  // memory model with 0 to 3 cycles of random latency
  int unsigned wait_cnt;
  logic busy;
  always @(posedge clk) begin
    if (reset) begin
      mem_ready <= 1'b0;
      busy = 1'b0;
    end else if (mem_valid && mem_ready) begin
      for (int i = 0; i < 4; i++) begin
        if (mem_wstrb[i]) begin
          mem[mem_addr[11:2]][8*i +: 8] <= mem_wdata[8*i +: 8];
        end
      end
      mem_ready <= 1'b0;
      busy = 1'b0;
    end else if (mem_valid && !busy) begin
      busy = 1'b1;
      wait_cnt = $urandom % 4;
      if (wait_cnt == 0) begin
        mem_ready <= 1'b1;
        mem_rdata <= mem[mem_addr[11:2]];
      end
    end else if (busy && !mem_ready) begin
      wait_cnt--;
      if (wait_cnt == 0) begin
        mem_ready <= 1'b1;
        mem_rdata <= mem[mem_addr[11:2]];
      end
    end
  end

  // compares stores, request stability and silence after a trap
  logic held;
  word_t held_addr;
  word_t held_wdata;
  wstrb_t held_wstrb;
  logic held_instr;
  always @(posedge clk) begin
    if (!reset) begin
      if (trap && mem_valid) begin
        $display("error at %0t: memory request after trap", $time);
        errors++;
      end
      if (held && mem_valid && (mem_addr !== held_addr || mem_wdata !== held_wdata ||
          mem_wstrb !== held_wstrb || mem_instr !== held_instr)) begin
        $display("error at %0t: request changed before transfer", $time);
        errors++;
      end
      if (mem_valid && mem_ready && mem_wstrb != '0) begin
        if (mem_instr !== 1'b0) begin
          $display("error at %0t: store marked as instruction fetch", $time);
          errors++;
        end
        if (store_idx >= exp_addr.size()) begin
          $display("error at %0t: unexpected store to %h", $time, mem_addr);
          errors++;
        end else if (mem_addr !== exp_addr[store_idx] || mem_wdata !== exp_data[store_idx] ||
                     mem_wstrb !== 4'hf) begin
          $display("error at %0t: store %0d got %h=%h/%h, expected %h=%h/f", $time,
                   store_idx, mem_addr, mem_wdata, mem_wstrb,
                   exp_addr[store_idx], exp_data[store_idx]);
          errors++;
        end
        store_idx++;
      end
    end
    held = mem_valid && !mem_ready;
    held_addr = mem_addr;
    held_wdata = mem_wdata;
    held_wstrb = mem_wstrb;
    held_instr = mem_instr;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > budget) begin
      $display("timeout: test did not finish within %0d cycles", budget);
      $display("Verification failed");
      $finish;
    end
  end

  task automatic run_test(string name);
    int unsigned errors_before;
    int unsigned n;
    errors_before = errors;
    @(posedge clk);
    reset <= 1'b1;
    for (int i = 0; i < 1024; i++) begin
      mem[i] = word_t'(i * 4) * 32'h9E37_79B9 + 32'h1234_5678;
    end
    for (int i = 0; i < prog_len; i++) begin
      mem[i] = prog[i];
    end
    ref_mem = mem;
    n = run_reference();
    store_idx = 0;
    cycle_count = 0;
    budget = n * 64 + 5000;
    repeat (3) @(posedge clk);
    @(negedge clk);
    if (mem_valid !== 1'b0 || mem_wstrb !== '0 || trap !== 1'b0) begin
      $display("error at %0t: outputs not idle in reset", $time);
      errors++;
    end
    @(posedge clk);
    reset <= 1'b0;
    // the first fetch request is up one cycle after reset is released
    repeat (2) @(negedge clk);
    if (mem_valid !== 1'b1 || mem_addr !== `RESET_PC || mem_instr !== 1'b1) begin
      $display("error at %0t: first fetch valid %b at %h, instr %b", $time, mem_valid,
               mem_addr, mem_instr);
      errors++;
    end
    while (!trap) @(negedge clk);
    repeat (20) @(negedge clk);
    if (store_idx != exp_addr.size()) begin
      $display("error at %0t: %0d stores seen, %0d expected", $time, store_idx,
               exp_addr.size());
      errors++;
    end
    if (trap !== exp_trap) begin
      $display("error at %0t: trap is %b, expected %b", $time, trap, exp_trap);
      errors++;
    end
    tests_run++;
    if (errors != errors_before) begin
      tests_failed++;
    end
    $display("%s: %0d instructions, %0d errors", name, n, errors - errors_before);
  endtask

  task automatic build_arith();
    word_t sh;
    begin_program();
    for (int r = 0; r < 2; r++) begin
      sh = $urandom;
      load_const(5'd1, $urandom);
      load_const(5'd2, $urandom);
      for (int f = 0; f < 8; f++) begin
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'(f), 5'd3));
        store_result(5'd3);
      end
      emit(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd3));
      store_result(5'd3);
      emit(enc_r(7'h20, 5'd2, 5'd1, 3'd5, 5'd3));
      store_result(5'd3);
      foreach (prog[k]) begin
        if (k < 8 && k != 1 && k != 5) begin
          emit(enc_i($urandom, 5'd1, 3'(k), 5'd3, opc_op_imm));
          store_result(5'd3);
        end
      end
      emit(enc_i({27'b0, sh[4:0]}, 5'd1, 3'd1, 5'd3, opc_op_imm));
      store_result(5'd3);
      emit(enc_i({27'b0, sh[9:5]}, 5'd1, 3'd5, 5'd3, opc_op_imm));
      store_result(5'd3);
      emit(enc_i({20'b0, 7'h20, sh[14:10]}, 5'd1, 3'd5, 5'd3, opc_op_imm));
      store_result(5'd3);
      // x0 must still read zero
      emit(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd0));
      store_result(5'd0);
      emit(enc_u($urandom, 5'd4, opc_lui));
      store_result(5'd4);
      emit(enc_u($urandom, 5'd5, opc_auipc));
      store_result(5'd5);
    end
    emit('0);
  endtask

  task automatic build_branches();
    int f3s [6] = '{0, 1, 4, 5, 6, 7};
    begin_program();
    for (int r = 0; r < 3; r++) begin
      for (int k = 0; k < 6; k++) begin
        load_const(5'd1, ($urandom % 4 == 0) ? 32'h5A5A : $urandom);
        load_const(5'd2, ($urandom % 2 == 0) ? 32'h5A5A : $urandom);
        emit(enc_b(32'd8, 5'd2, 5'd1, 3'(f3s[k])));
        store_result(5'd1);
        store_result(5'd2);
      end
    end
    emit(enc_j(32'd8, 5'd6));
    store_result(5'd1);
    store_result(5'd6);
    emit(enc_u('0, 5'd7, opc_auipc));
    emit(enc_i(32'd16, 5'd7, 3'd0, 5'd8, opc_jalr));
    store_result(5'd1);
    store_result(5'd1);
    store_result(5'd8);
    emit('0);
  endtask

  task automatic build_load_store();
    begin_program();
    for (int r = 0; r < 8; r++) begin
      load_const(5'd1, $urandom);
      load_const(5'd10, 32'h800 + 4 * ($urandom % 255));
      emit(enc_s('0, 5'd1, 5'd10));
      emit(enc_i('0, 5'd10, 3'b010, 5'd11, opc_load));
      store_result(5'd11);
      emit(enc_i(32'd4, 5'd10, 3'b010, 5'd12, opc_load));
      store_result(5'd12);
    end
    emit('0);
  endtask

  task automatic build_mul_div();
    begin_program();
    for (int r = 0; r < 4; r++) begin
      load_const(5'd1, $urandom);
      load_const(5'd2, (r == 3) ? 32'h0 : (r == 2) ? $urandom % 256 : $urandom);
      emit(enc_r(7'h01, 5'd2, 5'd1, 3'd0, 5'd3));
      store_result(5'd3);
      emit(enc_r(7'h01, 5'd2, 5'd1, 3'd5, 5'd3));
      store_result(5'd3);
      emit(enc_r(7'h01, 5'd2, 5'd1, 3'd7, 5'd3));
      store_result(5'd3);
    end
    emit('0);
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    mem_ready = 1'b0;
    mem_rdata = '0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    cycle_count = 0;
    budget = 5000;
    held = 1'b0;
    busy = 1'b0;
    void'($urandom(43034));
    build_arith();
    run_test("arith");
    build_branches();
    run_test("branch_jump");
    build_load_store();
    run_test("load_store");
    build_mul_div();
    run_test("mul_div");
    begin_program();
    load_const(5'd1, $urandom);
    store_result(5'd1);
    emit(32'hFFFF_FFFF);
    store_result(5'd1);
    run_test("illegal");
    begin_program();
    emit(enc_i(32'h402, 5'd0, 3'd0, 5'd1, opc_op_imm));
    emit(enc_i('0, 5'd1, 3'b010, 5'd2, opc_load));
    store_result(5'd1);
    run_test("misaligned_lw");
    begin_program();
    emit(enc_i(32'h22, 5'd0, 3'd0, 5'd1, opc_op_imm));
    emit(enc_i('0, 5'd1, 3'd0, 5'd3, opc_jalr));
    store_result(5'd1);
    run_test("misaligned_jalr");
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+logic
+incdir+testbench
logic/rv_isa_pkg.sv
logic/core_ctrl_pkg.sv
logic/instr_decoder.sv
logic/reg_file.sv
logic/exec_unit.sv
logic/mul_div_unit.sv
logic/step_counter.sv
logic/core_fsm.sv
logic/riscv_core.sv
testbench/tb_riscv_core.sv

// ==== Bender.yml ====
package:
  name: riscv_core

sources:
  - include_dirs:
      - logic
    files:
      - logic/rv_isa_pkg.sv
      - logic/core_ctrl_pkg.sv
      - logic/instr_decoder.sv
      - logic/reg_file.sv
      - logic/exec_unit.sv
      - logic/mul_div_unit.sv
      - logic/step_counter.sv
      - logic/core_fsm.sv
      - logic/riscv_core.sv
  - target: test
    include_dirs:
      - logic
      - testbench
    files:
      - testbench/tb_riscv_core.sv
